/* verification/aes_kv_stimulus.txt */
# cap: kv_en block key_bytes beats sw_re exp_valid exp_lost exp_masked
# clr: source(1 write-done, 2 data-out clear, 3 clear secrets) exp_valid, rest zero
# edn: clearing_req masking_req drop_masking exp_clearing_ack exp_masking_ack, rest zero
cap 1 0 64 4 0 1 0 1
clr 1 0 0 0 0 0 0 0
cap 1 0 32 5 0 1 0 1
clr 2 0 0 0 0 0 0 0
cap 1 0 48 3 1 1 0 1
clr 3 0 0 0 0 0 0 0
cap 1 0 64 4 1 1 0 1
clr 3 0 0 0 0 0 0 0
cap 0 1 64 2 0 0 1 1
cap 0 1 64 3 1 0 1 1
cap 0 0 64 2 1 0 0 0
cap 0 0 64 3 0 0 0 0
edn 1 1 0 1 0 0 0 0
edn 0 1 0 0 1 0 0 0
edn 1 0 0 1 0 0 0 0
edn 0 1 1 0 0 0 0 0
edn 1 1 1 1 0 0 0 0

/* all.f */
+incdir+verilog
verilog/aes_kv_pkg.sv
verilog/aes_kv_capture_ctrl.sv
verilog/aes_kv_chunk_slot.sv
verilog/aes_kv_out_stage.sv
verilog/aes_edn_req_arbiter.sv
verilog/aes_kv_top.sv
verification/tb_aes_kv.sv

/* Makefile */
# Verilator build and run for the key-vault output path

TOP := tb_aes_kv

.PHONY: all lint clean

all:
	verilator --binary --assert --top-module $(TOP) -f all.f -o V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

lint:
	verilator --lint-only --timing --assert --top-module aes_kv_top -f all.f

clean:
	rm -rf obj_dir

/* verification/tb_aes_kv.sv */
/*
 * Testbench for the AES key-vault output path
 * Runs the steps of the stimulus file and rebuilds the expected
 * key-vault word from the beats it drives
 */

`include "aes_kv_defines.svh"

module tb_aes_kv
  import aes_kv_pkg::*;
();

  localparam int MaxWait = 100;

  logic        clk_i, rst_ni;
  logic        data_in_we_i, output_valid_de_i, output_valid_d_i, idle_de_i, idle_d_i;
  logic        kv_en_i, block_reg_output_i, sw_re_i;
  logic        clear_secrets_i, data_out_clear_i, kv_write_done_i;
  logic        clearing_req_i, masking_req_i, edn_ack_i;
  logic        clearing_ack_o, masking_ack_o, edn_req_o;
  logic        kv_data_valid_o, data_out_re_o, output_lost_set_o;
  key_size_t   key_size_i;
  chunk_t      data_out_i, sw_data_out_o;
  kv_word_t    kv_data_o;

  // What each slot should hold after the steps so far
  chunk_t      slot_model [`AES_KV_NUM_CHUNKS];
  int          fd;
  int          steps;
  int          n_fields;
  int          field [8];
  string       line;
  string       kind;
  int unsigned seed;

  aes_kv_top u_dut (.*);

  always #10 clk_i = ~clk_i;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic report_error(input string what);
    abort_run($sformatf("error at time %0t: %s", $time, what));
  endtask

  // Combinational outputs catch up with the inputs driven at the falling edge
  task automatic settle();
    #2;
  endtask

  task automatic wait_kv_valid();
    int n;
    n = 0;
    while (kv_data_valid_o !== 1'b1) begin
      if (n == MaxWait) begin
        abort_run($sformatf("Timed out after %0d cycles waiting for kv_data_valid_o", n));
      end
      @(negedge clk_i);
      n++;
    end
  endtask

  task automatic wait_edn_req(input logic level);
    int n;
    n = 0;
    settle();
    while (edn_req_o !== level) begin
      if (n == MaxWait) begin
        abort_run($sformatf("Timed out after %0d cycles waiting for edn_req_o", n));
      end
      @(negedge clk_i);
      settle();
      n++;
    end
  endtask

  task automatic check_slots();
    chunk_t got;
    for (int i = 0; i < `AES_KV_NUM_CHUNKS; i++) begin
      got = kv_data_o[i*`AES_KV_CHUNK_W +: `AES_KV_CHUNK_W];
      assert (got === slot_model[i]) else
        report_error($sformatf("slot %0d is %h, expected %h", i, got, slot_model[i]));
    end
  endtask

  ////////////////////////////////////////
  // Step kinds
  ////////////////////////////////////////

  // One core operation: arm, stream the beats, then return to idle
  task automatic run_capture(input logic kv_en, input logic block, input int key_bytes,
                             input int beats, input logic sw_re, input logic exp_valid,
                             input logic exp_lost, input logic exp_masked);
    chunk_t beat;
    int     thresh;
    thresh = key_bytes / 16 - 1;
    @(negedge clk_i);
    kv_en_i            = kv_en;
    block_reg_output_i = block;
    key_size_i         = key_size_t'(key_bytes);
    sw_re_i            = sw_re;
    data_in_we_i       = 1'b1;
    idle_de_i          = 1'b1;
    idle_d_i           = 1'b0;
    @(negedge clk_i);
    data_in_we_i = 1'b0;
    idle_de_i    = 1'b0;
    for (int i = 0; i < beats; i++) begin
      beat              = {$urandom, $urandom, $urandom, $urandom};
      data_out_i        = beat;
      output_valid_de_i = 1'b1;
      output_valid_d_i  = 1'b1;
      settle();
      assert (output_lost_set_o === exp_lost) else
        report_error($sformatf("output_lost_set_o is %b on beat %0d", output_lost_set_o, i));
      // Registered output-valid is still low here
      assert (data_out_re_o === (kv_en ? 1'b0 : sw_re)) else
        report_error($sformatf("data_out_re_o is %b before beat %0d", data_out_re_o, i));
      @(negedge clk_i);
      output_valid_d_i = 1'b0;
      settle();
      assert (output_lost_set_o === 1'b0) else
        report_error($sformatf("output_lost_set_o stays high after beat %0d", i));
      assert (sw_data_out_o === (exp_masked ? chunk_t'(0) : beat)) else
        report_error($sformatf("sw_data_out_o is %h on beat %0d", sw_data_out_o, i));
      assert (data_out_re_o === (kv_en ? 1'b1 : sw_re)) else
        report_error($sformatf("data_out_re_o is %b on beat %0d", data_out_re_o, i));
      @(negedge clk_i);
      output_valid_de_i = 1'b0;
      // Beats past the threshold keep landing in the last slot
      if (kv_en) begin
        slot_model[(i < thresh) ? i : thresh] = beat;
      end
    end
    idle_de_i = 1'b1;
    idle_d_i  = 1'b1;
    @(negedge clk_i);
    idle_de_i = 1'b0;
    if (exp_valid) begin
      wait_kv_valid();
    end else begin
      assert (kv_data_valid_o === 1'b0) else
        report_error("kv_data_valid_o rose without a key-vault capture");
    end
    check_slots();
  endtask

  task automatic run_clear(input int src, input logic exp_valid);
    @(negedge clk_i);
    kv_write_done_i  = (src == 1);
    data_out_clear_i = (src == 2);
    clear_secrets_i  = (src == 3);
    @(negedge clk_i);
    {kv_write_done_i, data_out_clear_i, clear_secrets_i} = '0;
    for (int i = 0; i < `AES_KV_NUM_CHUNKS; i++) begin
      slot_model[i] = '0;
    end
    assert (kv_data_valid_o === exp_valid) else
      report_error($sformatf("kv_data_valid_o is %b after clear source %0d",
                             kv_data_valid_o, src));
    check_slots();
  endtask

  task automatic run_edn(input logic clr_req, input logic mask_req, input logic drop_mask,
                         input logic exp_clr_ack, input logic exp_mask_ack);
    @(negedge clk_i);
    clearing_req_i = clr_req;
    masking_req_i  = mask_req;
    edn_ack_i      = 1'b0;
    wait_edn_req(1'b1);
    if (drop_mask) begin
      @(negedge clk_i);
      masking_req_i = 1'b0;
      settle();
      assert (edn_req_o === 1'b1) else
        report_error("edn_req_o dropped before the acknowledge");
    end
    @(negedge clk_i);
    edn_ack_i = 1'b1;
    settle();
    assert (clearing_ack_o === exp_clr_ack) else
      report_error($sformatf("clearing_ack_o is %b", clearing_ack_o));
    assert (masking_ack_o === exp_mask_ack) else
      report_error($sformatf("masking_ack_o is %b", masking_ack_o));
    @(negedge clk_i);
    {edn_ack_i, clearing_req_i, masking_req_i} = '0;
    wait_edn_req(1'b0);
  endtask

  initial begin
    seed  = $urandom(32'h9a3b);
    steps = 0;
    clk_i = 1'b0;
    rst_ni = 1'b0;
    {data_in_we_i, output_valid_de_i, output_valid_d_i, idle_de_i, idle_d_i} = '0;
    {kv_en_i, block_reg_output_i, sw_re_i} = '0;
    {clear_secrets_i, data_out_clear_i, kv_write_done_i} = '0;
    {clearing_req_i, masking_req_i, edn_ack_i} = '0;
    key_size_i = '0;
    data_out_i = '0;
    for (int i = 0; i < `AES_KV_NUM_CHUNKS; i++) begin
      slot_model[i] = '0;
    end
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;

    fd = $fopen("verification/aes_kv_stimulus.txt", "r");
    if (fd == 0) begin
      abort_run("Could not open the stimulus file");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line[0] == "#") begin
        continue;
      end
      n_fields = $sscanf(line, "%s %d %d %d %d %d %d %d %d", kind, field[0], field[1],
                         field[2], field[3], field[4], field[5], field[6], field[7]);
      if (n_fields != 9) begin
        abort_run({"Malformed stimulus line: ", line});
      end
      if (kind == "cap") begin
        run_capture(1'(field[0]), 1'(field[1]), field[2], field[3], 1'(field[4]),
                    1'(field[5]), 1'(field[6]), 1'(field[7]));
      end else if (kind == "clr") begin
        run_clear(field[0], 1'(field[1]));
      end else if (kind == "edn") begin
        run_edn(1'(field[0]), 1'(field[1]), 1'(field[2]), 1'(field[3]), 1'(field[4]));
      end else begin
        abort_run({"Unknown step kind in stimulus file: ", kind});
      end
      steps++;
    end
    $fclose(fd);
    if (steps == 0) begin
      abort_run("The stimulus file held no steps");
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

/* verilog/aes_kv_top.sv */
/*
 * AES key-vault output path top level
 * Capture controller, chunk slots, output stage and entropy arbiter
 */

`include "aes_kv_defines.svh"

module aes_kv_top
  import aes_kv_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,

  // Core status and data
  input  logic      data_in_we_i,
  input  logic      output_valid_de_i,
  input  logic      output_valid_d_i,
  input  logic      idle_de_i,
  input  logic      idle_d_i,
  input  chunk_t    data_out_i,

  // Firmware and key-vault control
  input  logic      kv_en_i,
  input  logic      block_reg_output_i,
  input  key_size_t key_size_i,
  input  logic      sw_re_i,
  input  logic      clear_secrets_i,
  input  logic      data_out_clear_i,
  input  logic      kv_write_done_i,

  // Key-vault and software outputs
  output kv_word_t  kv_data_o,
  output logic      kv_data_valid_o,
  output chunk_t    sw_data_out_o,
  output logic      data_out_re_o,
  output logic      output_lost_set_o,

  // Entropy requests
  input  logic      clearing_req_i,
  input  logic      masking_req_i,
  input  logic      edn_ack_i,
  output logic      clearing_ack_o,
  output logic      masking_ack_o,
  output logic      edn_req_o
);

  logic [`AES_KV_NUM_CHUNKS-1:0] slot_capture;
  logic                          kv_end;
  logic                          kv_clear;
  chunk_t                        slot_chunk [`AES_KV_NUM_CHUNKS];

  // Either secret clear source wipes the captured data
  assign kv_clear = clear_secrets_i | data_out_clear_i;

  ////////////////////////////////////////
  // Capture path
  ////////////////////////////////////////

  aes_kv_capture_ctrl u_capture_ctrl (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .data_in_we_i       (data_in_we_i),
    .kv_en_i            (kv_en_i),
    .block_reg_output_i (block_reg_output_i),
    .key_size_i         (key_size_i),
    .output_valid_de_i  (output_valid_de_i),
    .output_valid_d_i   (output_valid_d_i),
    .idle_de_i          (idle_de_i),
    .idle_d_i           (idle_d_i),
    .sw_re_i            (sw_re_i),
    .data_out_i         (data_out_i),
    .capture_o          (slot_capture),
    .end_o              (kv_end),
    .sw_data_out_o      (sw_data_out_o),
    .data_out_re_o      (data_out_re_o),
    .output_lost_set_o  (output_lost_set_o)
  );

  for (genvar i = 0; i < `AES_KV_NUM_CHUNKS; i++) begin : gen_slot
    aes_kv_chunk_slot u_slot (
      .clk_i     (clk_i),
      .rst_ni    (rst_ni),
      .capture_i (slot_capture[i]),
      .clear_i   (kv_clear),
      .done_i    (kv_write_done_i),
      .data_i    (data_out_i),
      .chunk_o   (slot_chunk[i])
    );
  end

  aes_kv_out_stage u_out_stage (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .chunks_i        (slot_chunk),
    .end_i           (kv_end),
    .clear_i         (kv_clear),
    .done_i          (kv_write_done_i),
    .kv_data_o       (kv_data_o),
    .kv_data_valid_o (kv_data_valid_o)
  );

  ////////////////////////////////////////
  // Entropy request arbitration
  ////////////////////////////////////////

  aes_edn_req_arbiter u_edn_arbiter (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .clearing_req_i (clearing_req_i),
    .masking_req_i  (masking_req_i),
    .edn_ack_i      (edn_ack_i),
    .clearing_ack_o (clearing_ack_o),
    .masking_ack_o  (masking_ack_o),
    .edn_req_o      (edn_req_o)
  );

endmodule

/* verilog/aes_edn_req_arbiter.sv */
/*
 * Entropy request arbiter
 * Clearing PRNG has priority over masking PRNG, and a request
 * stays up until the entropy source acknowledges it
 */

`include "aes_kv_defines.svh"

module aes_edn_req_arbiter (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic clearing_req_i,
  input  logic masking_req_i,
  input  logic edn_ack_i,
  output logic clearing_ack_o,
  output logic masking_ack_o,
  output logic edn_req_o
);

  logic hold_q;
  logic hold_d;

  assign edn_req_o = clearing_req_i | masking_req_i | hold_q;

  // Acknowledge goes only to the requester being served
  assign clearing_ack_o = clearing_req_i & edn_ack_i;
  assign masking_ack_o  = ~clearing_req_i & masking_req_i & edn_ack_i;

  // Keeps the handshake open if a requester drops out early
  assign hold_d = edn_req_o & ~edn_ack_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_q <= 1'b0;
    end else begin
      hold_q <= hold_d;
    end
  end

  acks_exclusive_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(clearing_ack_o && masking_ack_o));

endmodule

/* verilog/aes_kv_out_stage.sv */
/*
 * Key-vault output stage
 * Assembles the chunk slots into the key-vault word and
 * raises the data-valid flag at the end of the operation
 */

`include "aes_kv_defines.svh"

module aes_kv_out_stage
  import aes_kv_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  chunk_t   chunks_i [`AES_KV_NUM_CHUNKS],
  input  logic     end_i,
  input  logic     clear_i,
  input  logic     done_i,
  output kv_word_t kv_data_o,
  output logic     kv_data_valid_o
);

  logic valid_q;

  // Slot 0 sits in the low bits
  always_comb begin
    for (int i = 0; i < `AES_KV_NUM_CHUNKS; i++) begin
      kv_data_o[i*`AES_KV_CHUNK_W +: `AES_KV_CHUNK_W] = chunks_i[i];
    end
  end

  ////////////////////////////////////////
  // Valid toward the key vault
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (clear_i) begin
      valid_q <= 1'b0;
    end else if (end_i) begin
      valid_q <= 1'b1;
    end else if (done_i) begin
      valid_q <= 1'b0;
    end
  end

  assign kv_data_valid_o = valid_q;

  // Valid only rises after an end pulse that was not overridden by a clear
  valid_rise_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(kv_data_valid_o) |-> ($past(end_i) && !$past(clear_i)));

endmodule

/* verilog/aes_kv_chunk_slot.sv */
/*
 * Key-vault chunk slot
 * Holds one core output beat until cleared or consumed
 */

`include "aes_kv_defines.svh"

module aes_kv_chunk_slot
  import aes_kv_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   capture_i,
  input  logic   clear_i,
  input  logic   done_i,
  input  chunk_t data_i,
  output chunk_t chunk_o
);

  chunk_t chunk_q;

  // Secret clear wins over capture, write-done is lowest
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      chunk_q <= '0;
    end else if (clear_i) begin
      chunk_q <= '0;
    end else if (capture_i) begin
      chunk_q <= data_i;
    end else if (done_i) begin
      chunk_q <= '0;
    end
  end

  assign chunk_o = chunk_q;

  // A clear always leaves the slot empty, even with a beat arriving
  clear_empties_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    clear_i |=> (chunk_o == '0));

endmodule

/* verilog/aes_kv_capture_ctrl.sv */
/*
 * Key-vault capture controller
 * Arms on the first data-in write, counts output beats up to the
 * key-size threshold, flags the end of the operation and masks
 * the software read path while capture is active
 */

`include "aes_kv_defines.svh"

module aes_kv_capture_ctrl
  import aes_kv_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          data_in_we_i,
  input  logic                          kv_en_i,
  input  logic                          block_reg_output_i,
  input  key_size_t                     key_size_i,
  input  logic                          output_valid_de_i,
  input  logic                          output_valid_d_i,
  input  logic                          idle_de_i,
  input  logic                          idle_d_i,
  input  logic                          sw_re_i,
  input  chunk_t                        data_out_i,
  output logic [`AES_KV_NUM_CHUNKS-1:0] capture_o,
  output logic                          end_o,
  output chunk_t                        sw_data_out_o,
  output logic                          data_out_re_o,
  output logic                          output_lost_set_o
);

  // Bytes per output beat, used to scale the key size
  localparam int unsigned BeatBytes = `AES_KV_CHUNK_W / 8;

  logic       intercept_q;
  logic       mask_en_q;
  logic       output_valid_q;
  logic       idle_q;
  chunk_idx_t cnt_q;
  chunk_idx_t thresh;
  logic       capture_en;

  ////////////////////////////////////////
  // Core status tracking
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      output_valid_q <= 1'b0;
    end else if (output_valid_de_i) begin
      output_valid_q <= output_valid_d_i;
    end
  end

  // Core comes out of reset idle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idle_q <= 1'b1;
    end else if (idle_de_i) begin
      idle_q <= idle_d_i;
    end
  end

  ////////////////////////////////////////
  // Arming and end of operation
  ////////////////////////////////////////

  // Firmware arms the intercept before it starts the operation
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      intercept_q <= 1'b0;
      mask_en_q   <= 1'b1;
    end else if (data_in_we_i && (cnt_q == '0)) begin
      intercept_q <= kv_en_i;
      mask_en_q   <= ~(kv_en_i | block_reg_output_i);
    end else if (end_o) begin
      intercept_q <= 1'b0;
      mask_en_q   <= 1'b1;
    end
  end

  // Rounded down when the key size is not a whole number of beats
  assign thresh = chunk_idx_t'(key_size_i / BeatBytes - 1);

  // Core drops back to idle with the last beat already counted
  assign end_o = idle_de_i && idle_d_i && !idle_q && (cnt_q == thresh);

  ////////////////////////////////////////
  // Beat counter and slot select
  ////////////////////////////////////////

  assign capture_en = intercept_q && output_valid_q;

  // Saturates at the threshold so extra beats land in the last slot
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (!intercept_q) begin
      cnt_q <= '0;
    end else if (capture_en && (cnt_q != thresh)) begin
      cnt_q <= cnt_q + chunk_idx_t'(1);
    end
  end

  always_comb begin
    for (int i = 0; i < `AES_KV_NUM_CHUNKS; i++) begin
      capture_o[i] = capture_en && (cnt_q == chunk_idx_t'(i));
    end
  end

  ////////////////////////////////////////
  // Software read path
  ////////////////////////////////////////

  assign sw_data_out_o = mask_en_q ? data_out_i : '0;

  // Hardware drains the output itself while intercepting
  assign data_out_re_o = intercept_q ? output_valid_q : sw_re_i;

  assign output_lost_set_o = output_valid_de_i && output_valid_d_i && block_reg_output_i;

  // At most one slot loads per cycle
  capture_onehot_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(capture_o));

  // Counter stays within the key-size window during capture
  cnt_in_range_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    intercept_q |-> (cnt_q <= thresh));

endmodule

/* verilog/aes_kv_pkg.sv */
/*
 * Key-vault output path types
 * Chunk, key-vault word, chunk index and key size
 */

`include "aes_kv_defines.svh"

package aes_kv_pkg;

  // One 128-bit beat from the AES core
  typedef logic [`AES_KV_CHUNK_W-1:0] chunk_t;

  // Full word handed to the key vault, slot 0 in the low bits
  typedef logic [`AES_KV_WR_DW-1:0] kv_word_t;

  // Slot index, doubles as the beat counter
  typedef logic [$clog2(`AES_KV_NUM_CHUNKS)-1:0] chunk_idx_t;

  // Key size in bytes as programmed by firmware
  typedef logic [`AES_KV_KEY_SIZE_W-1:0] key_size_t;

endpackage

/* verilog/aes_kv_defines.svh */
/*
 * Key-vault output path and entropy request arbitration
 * Widths and counts shared by the RTL
 */

`ifndef AES_KV_DEFINES_SVH
`define AES_KV_DEFINES_SVH

// Key-vault write word, assembled from several core output beats
`define AES_KV_WR_DW 512

// One AES core output beat
`define AES_KV_CHUNK_W 128

// Chunk slots that make up one key-vault word
`define AES_KV_NUM_CHUNKS 4

// Key size field, counted in bytes
`define AES_KV_KEY_SIZE_W 7

`endif
